// File: verification/leader_tx_golden.txt
# name dx dy dz sl_en ms_en exp_dx exp_dy exp_dz exp_status push payload
# all hex except exp_status in binary as sl ms online; delays halved by the local rate
online_a      0010 0020 0030  7f 7f  0008 0010 0018  111  1  0123456789
online_b      0101 0203 0305  7f 7f  0080 0101 0182  111  0  1fedcba987
sl_lane3_low  1234 5678 9abc  77 7f  091a 2b3c 4d5e  010  1  0aaaaaaaaa
online_c      0001 0003 0007  7f 7f  0000 0001 0003  111  1  1555555555
online_d      fffe 8000 7fff  7f 7f  7fff 4000 3fff  111  0  0000000000
ms_lane0_low  00ff 0f0f a5a5  7f 7e  007f 0787 52d2  100  1  1fffffffff
ms_lane6_low  0400 0800 0c00  7f 3f  0200 0400 0600  100  1  0f0f0f0f0f
both_low      0000 0000 0000  00 00  0000 0000 0000  000  0  10f0f0f0f0
sl_lane6_low  3333 6666 9999  3f 7f  1999 3333 4ccc  010  1  0badc0ffee
online_e      2468 ace0 1357  7f 7f  1234 5670 09ab  111  1  1deadbeef0
online_f      0055 00aa 0100  7f 7f  002a 0055 0080  111  0  0000000001
online_g      c001 d003 e005  7f 7f  6000 6801 7002  111  1  1000000000
max_delay     ffff ffff ffff  7f 7f  7fff 7fff 7fff  111  1  0123401234
small_delay   0002 0004 0006  7f 7f  0001 0002 0003  111  0  1357913579

// File: filelist.f
+incdir+hw
hw/link_cfg_pkg.sv
hw/lane_pkg.sv
hw/link_cfg_sync.sv
hw/marker_gen.sv
hw/strobe_gen.sv
hw/lane_framer.sv
hw/leader_tx_top.sv
verification/leader_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the leader transmit regression with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project root"
   exit 1
fi

verilator --binary -f filelist.f --top-module leader_tx_tb -o leader_tx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/leader_tx_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi
exit 0

// File: verification/leader_tx_tb.sv
// Self-checking testbench for the leader transmit top
// Golden file stimulus with random payload fill between golden lines
// Per-cycle lane model for payload, push, marker and strobe

`timescale 1ns/1ns
`include "ca_consts.svh"

module leader_tx_tb;

   import link_cfg_pkg::*;
   import lane_pkg::*;

   localparam int CLK_HALF  = 4;                // 8 ns period
   localparam int MAX_LINES = 32;
   localparam int HOLD      = 56;               // Cycles per golden line
   localparam int MRK_P     = int'(RATE_QUARTER) / int'(RATE_HALF);
   localparam int STB_I     = `CA_TX_STB_INTV * int'(RATE_QUARTER) / int'(RATE_HALF);

   logic                       m_wr_clk = 1'b0;
   logic                       m_wr_rst_n;
   logic [`CA_DELAY_BITS-1:0]  i_delay_x;
   logic [`CA_DELAY_BITS-1:0]  i_delay_y;
   logic [`CA_DELAY_BITS-1:0]  i_delay_z;
   logic [`CA_NUM_LANES-1:0]   i_sl_transfer_en;
   logic [`CA_NUM_LANES-1:0]   i_ms_transfer_en;
   logic                       i_push;
   lane_payload_arr_t          i_payload;
   delay_cfg_t                 o_delay_cfg;
   link_status_t               o_status;
   lane_word_arr_t             o_tx_lane;

   // Golden table
   logic [127:0]               g_name      [MAX_LINES];
   delay_cfg_t                 g_delay_in  [MAX_LINES];
   delay_cfg_t                 g_delay_exp [MAX_LINES];
   logic [`CA_NUM_LANES-1:0]   g_sl        [MAX_LINES];
   logic [`CA_NUM_LANES-1:0]   g_ms        [MAX_LINES];
   link_status_t               g_status    [MAX_LINES];
   logic                       g_push      [MAX_LINES];
   lane_payload_t              g_payload   [MAX_LINES];
   int                         n_lines = 0;

   logic [127:0]               cur_name;    // Test currently driven
   logic [127:0]               name_prev;
   logic [31:0]                rnd_hi;
   logic [31:0]                rnd_lo;

   // Lane model state for the cycle before the next edge
   logic                       rst_prev    = 1'b0;
   logic                       en_prev     = 1'b0;
   logic                       push_prev   = 1'b0;
   lane_payload_arr_t          pay_prev    = '0;
   logic                       mdl_online  = 1'b0;
   logic                       mdl_marker  = 1'b0;
   logic                       mdl_strobe  = 1'b0;
   logic                       stb_started = 1'b0;
   int                         run_edges   = 0;   // Edges out of reset
   int                         on_cycles   = 0;   // Consecutive online cycles
   int                         since_stb   = 0;
   int                         stb_count   = 0;
   lane_word_t                 exp_w;

   leader_tx_top #(.LOCAL_RATE(RATE_HALF), .REMOTE_RATE(RATE_QUARTER)) dut (
      .m_wr_clk         (m_wr_clk),
      .m_wr_rst_n       (m_wr_rst_n),
      .i_delay_x        (i_delay_x),
      .i_delay_y        (i_delay_y),
      .i_delay_z        (i_delay_z),
      .i_sl_transfer_en (i_sl_transfer_en),
      .i_ms_transfer_en (i_ms_transfer_en),
      .i_push           (i_push),
      .i_payload        (i_payload),
      .o_delay_cfg      (o_delay_cfg),
      .o_status         (o_status),
      .o_tx_lane        (o_tx_lane)
   );

   initial
   begin
      forever #CLK_HALF m_wr_clk = ~m_wr_clk;
   end

   // ----------------------------------------
   // Failure reporting and compare tasks
   // ----------------------------------------
   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_delay(input logic [127:0] tname, input delay_cfg_t exp_v,
                              input delay_cfg_t act_v);
      if (act_v !== exp_v)
      begin
         $display("FAIL %0s delay_cfg expected %h actual %h", tname, exp_v, act_v);
         abort_run();
      end
   endtask

   task automatic check_status(input logic [127:0] tname, input link_status_t exp_v,
                               input link_status_t act_v);
      if (act_v !== exp_v)
      begin
         $display("FAIL %0s status expected %b actual %b", tname, exp_v, act_v);
         abort_run();
      end
   endtask

   task automatic check_lane(input logic [127:0] tname, input int lane,
                             input lane_word_t exp_v, input lane_word_t act_v);
      if (act_v !== exp_v)
      begin
         $display("FAIL %0s lane %0d expected %h actual %h", tname, lane, exp_v, act_v);
         abort_run();
      end
   endtask

   // Lane 0 carries the base word and other lanes mix in a shifted lane index
   function automatic lane_payload_arr_t spread_payload(input lane_payload_t base);
      lane_payload_arr_t arr;
      for (int i = 0; i < `CA_NUM_LANES; i++)
         arr[i] = base ^ (lane_payload_t'(i) << (5 * i));
      return arr;
   endfunction

   task automatic load_golden();
      int                fd;
      int                n_fld;
      logic [8*200-1:0]  line_buf;
      logic [127:0]      f_name;
      logic [15:0]       f_dx, f_dy, f_dz, f_ex, f_ey, f_ez;
      logic [6:0]        f_sl, f_ms;
      logic [2:0]        f_st;
      logic              f_push;
      lane_payload_t     f_pay;
      fd = $fopen("verification/leader_tx_golden.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the golden file verification/leader_tx_golden.txt");
         abort_run();
      end
      else
      begin
         while (!$feof(fd) && n_lines < MAX_LINES)
         begin
            line_buf = '0;
            if ($fgets(line_buf, fd) != 0)
            begin
               // Comment and blank lines match fewer fields
               n_fld = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %b %h %h", f_name,
                               f_dx, f_dy, f_dz, f_sl, f_ms, f_ex, f_ey, f_ez, f_st,
                               f_push, f_pay);
               if (n_fld == 12)
               begin
                  g_name[n_lines]      = f_name;
                  g_delay_in[n_lines]  = '{delay_x: f_dx, delay_y: f_dy, delay_z: f_dz};
                  g_delay_exp[n_lines] = '{delay_x: f_ex, delay_y: f_ey, delay_z: f_ez};
                  g_sl[n_lines]        = f_sl;
                  g_ms[n_lines]        = f_ms;
                  g_status[n_lines]    = link_status_t'(f_st);
                  g_push[n_lines]      = f_push;
                  g_payload[n_lines]   = f_pay;
                  n_lines++;
               end
            end
         end
         $fclose(fd);
         if (n_lines == 0)
         begin
            $display("The golden file holds no test lines");
            abort_run();
         end
      end
   endtask

   // ----------------------------------------
   // Lane monitor with marker and strobe model
   // ----------------------------------------
   always @(negedge m_wr_clk)
   begin
      for (int i = 0; i < `CA_NUM_LANES; i++)
      begin
         exp_w.marker  = rst_prev & mdl_marker;
         exp_w.payload = rst_prev ? pay_prev[i] : '0;
         exp_w.strobe  = rst_prev & mdl_strobe;
         exp_w.push    = rst_prev & push_prev & (i == 0);   // Push on lane 0 only
         check_lane(name_prev, i, exp_w, o_tx_lane[i]);
      end
      if (rst_prev)
      begin
         run_edges++;
         mdl_online = en_prev;                              // Status one cycle late
         mdl_marker = ((run_edges - 1) % MRK_P) == (MRK_P - 1);
         mdl_strobe = 1'b0;
         on_cycles  = mdl_online ? on_cycles + 1 : 0;
         since_stb  = since_stb + 1;
         if (!mdl_online)
            stb_started = 1'b0;                             // Drop restarts the sequence
         else if (stb_started ? (since_stb >= STB_I) : (on_cycles >= 2))
            mdl_strobe = mdl_marker;                        // Only on a marker
         if (mdl_strobe)
         begin
            stb_started = 1'b1;
            since_stb   = 0;
            stb_count++;
         end
      end
      else
      begin
         run_edges   = 0;
         mdl_marker  = 1'b0;
         mdl_strobe  = 1'b0;
         on_cycles   = 0;
         stb_started = 1'b0;
      end
      rst_prev  = m_wr_rst_n;
      en_prev   = &{i_sl_transfer_en, i_ms_transfer_en};
      push_prev = i_push;
      pay_prev  = i_payload;
      name_prev = cur_name;
   end

   // Watchdog sized from the golden line count
   initial
   begin
      wait (n_lines > 0);
      repeat (n_lines * 64 + 2000) @(posedge m_wr_clk);
      $display("Timeout: the run did not finish in the expected number of cycles");
      abort_run();
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial
   begin
      rnd_lo           = $urandom(32'h002dd122);   // Seed once
      m_wr_rst_n       = 1'b0;
      i_delay_x        = 16'hffff;                  // Non-zero during reset
      i_delay_y        = 16'hffff;
      i_delay_z        = 16'hffff;
      i_sl_transfer_en = 7'h7f;
      i_ms_transfer_en = 7'h7f;
      i_push           = 1'b1;
      i_payload        = '1;
      cur_name         = "reset";
      load_golden();
      repeat (3) @(posedge m_wr_clk);
      @(negedge m_wr_clk);
      check_delay(cur_name, '0, o_delay_cfg);
      check_status(cur_name, '0, o_status);
      for (int l = 0; l < `CA_NUM_LANES; l++)
         check_lane(cur_name, l, '0, o_tx_lane[l]);
      @(posedge m_wr_clk);
      m_wr_rst_n <= 1'b1;                           // Fourth reset edge passes here
      for (int t = 0; t < n_lines; t++)
      begin
         for (int k = 0; k < HOLD; k++)
         begin
            @(posedge m_wr_clk);
            if (k == 0)
            begin
               cur_name          = g_name[t];
               i_delay_x        <= g_delay_in[t].delay_x;
               i_delay_y        <= g_delay_in[t].delay_y;
               i_delay_z        <= g_delay_in[t].delay_z;
               i_sl_transfer_en <= g_sl[t];
               i_ms_transfer_en <= g_ms[t];
               i_push           <= g_push[t];
               i_payload        <= spread_payload(g_payload[t]);
            end
            else
            begin
               rnd_hi     = $urandom;
               rnd_lo     = $urandom;
               i_push    <= rnd_hi[31];
               i_payload <= spread_payload({rnd_hi[4:0], rnd_lo});
            end
            @(negedge m_wr_clk);
            if (k == 1)
               check_status(cur_name, g_status[t], o_status);
            if (k == 2)
               check_delay(cur_name, g_delay_exp[t], o_delay_cfg);
         end
      end
      @(posedge m_wr_clk);
      @(negedge m_wr_clk);                          // Last payload reaches the lanes
      @(posedge m_wr_clk);                          // Lane monitor has checked it
      if (stb_count < 4)
      begin
         $display("Too few strobes were seen over the whole run");
         abort_run();
      end
      else
      begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

// File: hw/leader_tx_top.sv
// Leader transmit top
// Delay and status sync, marker and strobe generation, lane framing

`timescale 1ns/1ns
`include "ca_consts.svh"

module leader_tx_top #(
   parameter link_cfg_pkg::rate_e LOCAL_RATE  = link_cfg_pkg::RATE_FULL,
   parameter link_cfg_pkg::rate_e REMOTE_RATE = link_cfg_pkg::RATE_HALF
) (
   input  logic                          m_wr_clk,
   input  logic                          m_wr_rst_n,
   input  logic [`CA_DELAY_BITS-1:0]     i_delay_x,
   input  logic [`CA_DELAY_BITS-1:0]     i_delay_y,
   input  logic [`CA_DELAY_BITS-1:0]     i_delay_z,
   input  logic [`CA_NUM_LANES-1:0]      i_sl_transfer_en,
   input  logic [`CA_NUM_LANES-1:0]      i_ms_transfer_en,
   input  logic                          i_push,
   input  lane_pkg::lane_payload_arr_t   i_payload,
   output link_cfg_pkg::delay_cfg_t      o_delay_cfg,
   output link_cfg_pkg::link_status_t    o_status,
   output lane_pkg::lane_word_arr_t      o_tx_lane
);

   logic tx_marker;                             // Remote word boundary
   logic tx_strobe;                             // Alignment strobe

   // ----------------------------------------
   // Configuration and status
   // ----------------------------------------
   link_cfg_sync #(.LOCAL_RATE(LOCAL_RATE)) u_link_cfg_sync (
      .m_wr_clk         (m_wr_clk),
      .m_wr_rst_n       (m_wr_rst_n),
      .i_delay_x        (i_delay_x),
      .i_delay_y        (i_delay_y),
      .i_delay_z        (i_delay_z),
      .i_sl_transfer_en (i_sl_transfer_en),
      .i_ms_transfer_en (i_ms_transfer_en),
      .o_delay_cfg      (o_delay_cfg),
      .o_status         (o_status)
   );

   // ----------------------------------------
   // Marker and strobe
   // ----------------------------------------
   marker_gen #(.LOCAL_RATE(LOCAL_RATE), .REMOTE_RATE(REMOTE_RATE)) u_marker_gen (
      .m_wr_clk         (m_wr_clk),
      .m_wr_rst_n       (m_wr_rst_n),
      .o_marker         (tx_marker)
   );

   strobe_gen #(.LOCAL_RATE(LOCAL_RATE), .REMOTE_RATE(REMOTE_RATE)) u_strobe_gen (
      .m_wr_clk         (m_wr_clk),
      .m_wr_rst_n       (m_wr_rst_n),
      .i_online         (o_status.tx_online),   // Registered online level
      .i_marker         (tx_marker),
      .o_strobe         (tx_strobe)
   );

   lane_framer u_lane_framer (
      .m_wr_clk         (m_wr_clk),
      .m_wr_rst_n       (m_wr_rst_n),
      .i_payload        (i_payload),
      .i_push           (i_push),
      .i_strobe         (tx_strobe),
      .i_marker         (tx_marker),
      .o_tx_lane        (o_tx_lane)
   );

endmodule

// File: hw/lane_framer.sv
// Lane word framer
// Places payload, push, strobe and marker at their bit locations
// Registers all seven lane words

`timescale 1ns/1ns
`include "ca_consts.svh"

module lane_framer (
   input  logic                          m_wr_clk,
   input  logic                          m_wr_rst_n,
   input  lane_pkg::lane_payload_arr_t   i_payload,   // One payload per lane
   input  logic                          i_push,      // Valid word this cycle
   input  logic                          i_strobe,
   input  logic                          i_marker,
   output lane_pkg::lane_word_arr_t      o_tx_lane
);

   import lane_pkg::*;

   lane_word_arr_t lane_d;                      // Framed words before the register

   // Pack one word by bit location
   function automatic lane_word_t frame_word(input lane_payload_t payload,
                                             input logic          push,
                                             input logic          strobe,
                                             input logic          marker);
      logic [`CA_LANE_BITS-1:0] raw;
      raw = '0;
      raw[`CA_PUSH_LOC]                         = push;
      raw[`CA_STROBE_LOC]                       = strobe;
      raw[`CA_MARKER_LOC-1:`CA_STROBE_LOC+1]    = payload;
      raw[`CA_MARKER_LOC]                       = marker;
      return lane_word_t'(raw);
   endfunction

   // ----------------------------------------
   // Framing
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < `CA_NUM_LANES; i++)
      begin
         // Push only rides on lane 0
         lane_d[i] = frame_word(i_payload[i], (i == 0) ? i_push : 1'b0, i_strobe, i_marker);
      end
   end

   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
         o_tx_lane <= '0;
      else
         o_tx_lane <= lane_d;                   // One cycle after payload
   end

endmodule

// File: hw/strobe_gen.sv
// Alignment strobe generator
// FSM waits for online then a marker, then repeats every scaled interval
// Each strobe lands on a marker cycle

`timescale 1ns/1ns
`include "ca_consts.svh"

module strobe_gen #(
   parameter link_cfg_pkg::rate_e LOCAL_RATE  = link_cfg_pkg::RATE_FULL,
   parameter link_cfg_pkg::rate_e REMOTE_RATE = link_cfg_pkg::RATE_HALF
) (
   input  logic   m_wr_clk,
   input  logic   m_wr_rst_n,
   input  logic   i_online,                     // Link ready level
   input  logic   i_marker,                     // Remote word boundary
   output logic   o_strobe
);

   localparam int STB_INTV = (`CA_TX_STB_INTV * int'(REMOTE_RATE)) / int'(LOCAL_RATE);
   localparam int CNT_W    = $clog2(STB_INTV + 1);

   localparam logic [CNT_W-1:0] CNT_TGT = CNT_W'(STB_INTV);

   typedef enum logic [1:0]
   {
      STB_OFFLINE,                              // Link down
      STB_WAIT_MARKER,                          // First strobe pending
      STB_COUNT                                 // Spacing strobes
   } stb_state_e;

   stb_state_e       state_q;
   stb_state_e       state_d;
   logic [CNT_W-1:0] stb_cnt;                   // Cycles since last strobe
   logic             stb_hit;

   // ----------------------------------------
   // Next state and strobe decode
   // ----------------------------------------
   always_comb
   begin
      state_d = state_q;
      stb_hit = 1'b0;
      case (state_q)
         STB_OFFLINE:
            if (i_online)
               state_d = STB_WAIT_MARKER;
         STB_WAIT_MARKER:
            if (i_marker)
            begin
               stb_hit = 1'b1;                  // Sequence starts here
               state_d = STB_COUNT;
            end
         STB_COUNT:
            stb_hit = (stb_cnt >= CNT_TGT) && i_marker;
         default:
            state_d = STB_OFFLINE;
      endcase
      if (!i_online)
      begin
         state_d = STB_OFFLINE;                 // Drop restarts the sequence
         stb_hit = 1'b0;
      end
   end

   assign o_strobe = stb_hit;

   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         state_q <= STB_OFFLINE;
         stb_cnt <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (stb_hit)
            stb_cnt <= CNT_W'(1);               // Next cycle is one after strobe
         else if (state_q == STB_COUNT && stb_cnt < CNT_TGT)
            stb_cnt <= stb_cnt + 1'b1;          // Saturates at the target
      end
   end

endmodule

// File: hw/marker_gen.sv
// Remote word marker generator
// Free-running counter over the remote to local rate ratio

`timescale 1ns/1ns

module marker_gen #(
   parameter link_cfg_pkg::rate_e LOCAL_RATE  = link_cfg_pkg::RATE_FULL,
   parameter link_cfg_pkg::rate_e REMOTE_RATE = link_cfg_pkg::RATE_HALF
) (
   input  logic   m_wr_clk,
   input  logic   m_wr_rst_n,
   output logic   o_marker                      // One cycle per remote word
);

   // Local words per remote word, never below one
   localparam int MRK_RATIO  = int'(REMOTE_RATE) / int'(LOCAL_RATE);
   localparam int MRK_PERIOD = (MRK_RATIO < 1) ? 1 : MRK_RATIO;
   localparam int CNT_W      = (MRK_PERIOD > 1) ? $clog2(MRK_PERIOD) : 1;

   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MRK_PERIOD - 1);

   logic [CNT_W-1:0] mrk_cnt;                   // Local word index
   logic             cnt_wrap;                  // Last local word

   assign cnt_wrap = (mrk_cnt == CNT_LAST);

   // ----------------------------------------
   // Counter and registered pulse
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         mrk_cnt  <= '0;
         o_marker <= 1'b0;                      // Quiet through reset
      end
      else
      begin
         mrk_cnt  <= cnt_wrap ? '0 : mrk_cnt + 1'b1;
         // With a period of one the wrap is constant so the marker stays high
         o_marker <= cnt_wrap;
      end
   end

endmodule

// File: hw/link_cfg_sync.sv
// Delay setting capture and lane enable reduction
// Two register stages per delay then division by the local rate
// Seven-lane transfer enables reduced to registered status levels

`timescale 1ns/1ns
`include "ca_consts.svh"

module link_cfg_sync #(
   parameter link_cfg_pkg::rate_e LOCAL_RATE = link_cfg_pkg::RATE_FULL
) (
   input  logic                        m_wr_clk,
   input  logic                        m_wr_rst_n,
   input  logic [`CA_DELAY_BITS-1:0]   i_delay_x,          // Static level
   input  logic [`CA_DELAY_BITS-1:0]   i_delay_y,
   input  logic [`CA_DELAY_BITS-1:0]   i_delay_z,
   input  logic [`CA_NUM_LANES-1:0]    i_sl_transfer_en,   // One bit per lane
   input  logic [`CA_NUM_LANES-1:0]    i_ms_transfer_en,
   output link_cfg_pkg::delay_cfg_t    o_delay_cfg,
   output link_cfg_pkg::link_status_t  o_status
);

   import link_cfg_pkg::*;

   localparam logic [`CA_DELAY_BITS-1:0] RATE_DIV = `CA_DELAY_BITS'(LOCAL_RATE);

   delay_cfg_t dly_s1;                          // First capture stage
   delay_cfg_t dly_s2;                          // Settled copy

   // ----------------------------------------
   // Delay capture
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         dly_s1 <= '0;
         dly_s2 <= '0;
      end
      else
      begin
         dly_s1 <= '{delay_x: i_delay_x, delay_y: i_delay_y, delay_z: i_delay_z};
         dly_s2 <= dly_s1;
      end
   end

   // Scale to local words, truncating
   assign o_delay_cfg.delay_x = dly_s2.delay_x / RATE_DIV;
   assign o_delay_cfg.delay_y = dly_s2.delay_y / RATE_DIV;
   assign o_delay_cfg.delay_z = dly_s2.delay_z / RATE_DIV;

   // ----------------------------------------
   // Online status
   // ----------------------------------------
   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
         o_status <= '0;
      else
      begin
         o_status.sl_transfer_en <= &i_sl_transfer_en;                     // Every lane up
         o_status.ms_transfer_en <= &i_ms_transfer_en;
         o_status.tx_online      <= &{i_sl_transfer_en, i_ms_transfer_en}; // Both sides up
      end
   end

endmodule

// File: hw/lane_pkg.sv
// Lane word types
// Per-lane payload, framed lane word and seven-lane bundles

`include "ca_consts.svh"

package lane_pkg;

   typedef logic [`CA_PAYLOAD_BITS-1:0] lane_payload_t;   // User bits of one lane

   // Framed word as sent to the phy, top bit first
   typedef struct packed
   {
      logic          marker;                   // Bit 39
      lane_payload_t payload;                  // Bits 38 down to 2
      logic          strobe;                   // Bit 1
      logic          push;                     // Bit 0
   } lane_word_t;

   // ----------------------------------------
   // Seven-lane bundles, lane 0 in the low slot
   // ----------------------------------------
   typedef lane_payload_t [`CA_NUM_LANES-1:0] lane_payload_arr_t;
   typedef lane_word_t    [`CA_NUM_LANES-1:0] lane_word_arr_t;

endpackage

// File: hw/link_cfg_pkg.sv
// Link configuration types
// Lane rate encoding, delay setting bundle and online status bundle

`include "ca_consts.svh"

package link_cfg_pkg;

   // Lane rate as words per remote clock, kept 4 bits wide
   typedef enum logic [3:0]
   {
      RATE_FULL    = 4'h1,                     // One word per cycle
      RATE_HALF    = 4'h2,                     // Two words per cycle
      RATE_QUARTER = 4'h4                      // Four words per cycle
   } rate_e;

   // Alignment delays after rate scaling
   typedef struct packed
   {
      logic [`CA_DELAY_BITS-1:0] delay_x;      // Word alignment time
      logic [`CA_DELAY_BITS-1:0] delay_y;      // Channel alignment time
      logic [`CA_DELAY_BITS-1:0] delay_z;      // Phy alignment time
   } delay_cfg_t;

   // Reduced transfer enables
   typedef struct packed
   {
      logic sl_transfer_en;                    // All follower lanes ready
      logic ms_transfer_en;                    // All leader lanes ready
      logic tx_online;                         // Both directions ready
   } link_status_t;

endpackage

// File: hw/ca_consts.svh
// Shared constants for the leader transmit lanes
// Lane geometry, framing bit locations, strobe interval and delay width

`ifndef CA_CONSTS_SVH
`define CA_CONSTS_SVH

// ----------------------------------------
// Lane geometry
// ----------------------------------------
`define CA_NUM_LANES      7       // Lanes per direction
`define CA_LANE_BITS      40      // Full lane word
`define CA_PAYLOAD_BITS   37      // Bits 2 up to 38

// ----------------------------------------
// Framing bit locations
// ----------------------------------------
`define CA_PUSH_LOC       0       // Push bit
`define CA_STROBE_LOC     1       // Alignment strobe
`define CA_MARKER_LOC     39      // Remote word marker

// Base strobe interval in remote words
`define CA_TX_STB_INTV    24
`define CA_DELAY_BITS     16      // X, Y and Z delay values

`endif
